/* source/burst_mem_pkg.sv */
/*
 * shared sizes, enums and packed structs of the burst memory subsystem
 * covers the wishbone port, the cache line, the sequencer and the burst RAM
 */

package burst_mem_pkg;

  localparam int RAM_ADDR_W   = 6;   // 64 words of 64 bits
  localparam int RAM_DATA_W   = 64;
  localparam int RAM_DEPTH    = 2 ** RAM_ADDR_W;
  localparam int BURST_LEN    = 4;   // beats per burst
  localparam int INIT_CYCLES  = 10;  // calibration delay after reset
  localparam int READ_LATENCY = 6;   // accept to first valid beat
  localparam int WB_ADR_W     = 7;   // in 32-bit words
  localparam int WB_DATA_W    = 32;
  localparam int WB_SEL_W     = 4;
  localparam int TAG_W        = 4;   // line number, upper wishbone address bits

  localparam int LINE_W     = BURST_LEN * RAM_DATA_W;
  localparam int LINE_WORDS = LINE_W / WB_DATA_W;
  localparam int WORD_IDX_W = $clog2(LINE_WORDS);
  localparam int BEAT_IDX_W = $clog2(BURST_LEN);
  localparam int INIT_CNT_W = $clog2(INIT_CYCLES + 1);
  localparam int LAT_CNT_W  = $clog2(READ_LATENCY);

  typedef enum logic {CMD_READ = 1'b0, CMD_WRITE = 1'b1} ram_cmd_e;

  typedef enum logic [2:0] {INITIATE, IDLE, READ_DELAY, READ_BURST, WRITE_BURST} ram_state_e;

  typedef enum logic {SEQ_FILL, SEQ_EVICT} seq_op_e;

  typedef enum logic [2:0] {
    SEQ_IDLE, SEQ_ISSUE, SEQ_WR_BEATS, SEQ_WR_WAIT, SEQ_RD_BEATS, SEQ_DONE
  } seq_state_e;

  typedef enum logic [1:0] {CTRL_IDLE, CTRL_EVICT, CTRL_FILL} ctrl_state_e;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADR_W-1:0]  adr;
    logic [WB_DATA_W-1:0] dat_w;
    logic [WB_SEL_W-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic [WB_DATA_W-1:0] dat_r;
    logic                 ack;
  } wb_rsp_t;

  typedef struct packed {
    logic                  cmd_en;
    ram_cmd_e              cmd;
    logic [RAM_ADDR_W-1:0] addr;
    logic [RAM_DATA_W-1:0] wr_data;
  } ram_req_t;

  typedef struct packed {
    logic [RAM_DATA_W-1:0] rd_data;
    logic                  rd_data_valid;
    logic                  init_calib;
    logic                  busy;
  } ram_rsp_t;

  typedef struct packed {
    logic             start;
    seq_op_e          op;
    logic [TAG_W-1:0] tag;
  } seq_req_t;

endpackage

/* source/burst_ram.sv */
/*
 * cycle-level model of an external burst RAM controller core
 * calibration delay, fixed read latency, four-beat read and write bursts
 */

module burst_ram
  import burst_mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  ram_req_t ram_req,
  output ram_rsp_t ram_rsp
);

  logic [RAM_DATA_W-1:0] mem [RAM_DEPTH] = '{default: '0};  // starts all zero

  ram_state_e            state;
  logic [INIT_CNT_W-1:0] init_cnt;
  logic [LAT_CNT_W-1:0]  lat_cnt;
  logic [BEAT_IDX_W-1:0] burst_cnt;
  logic [RAM_ADDR_W-1:0] addr_cnt;   // next word of the burst
  logic [RAM_DATA_W-1:0] rd_data_q;
  logic                  rd_valid_q;
  logic                  calib_q;
  logic                  busy_q;

  logic                  burst_last;
  logic                  lat_last;
  logic                  accept;
  logic                  mem_we;
  logic [RAM_ADDR_W-1:0] mem_waddr;
  logic                  rd_load;

  assign burst_last = (burst_cnt == BEAT_IDX_W'(BURST_LEN - 1));
  assign lat_last   = (lat_cnt == LAT_CNT_W'(READ_LATENCY - 1));

  // a command is taken when idle, or back to back in the last burst cycle
  assign accept = ram_req.cmd_en &&
                  (state == IDLE ||
                   ((state == READ_BURST || state == WRITE_BURST) && burst_last));

  always_comb begin
    mem_we    = 1'b0;
    mem_waddr = addr_cnt;
    if (accept && ram_req.cmd == CMD_WRITE) begin
      mem_we    = 1'b1;       // beat 0 arrives with the command
      mem_waddr = ram_req.addr;
    end else if (state == WRITE_BURST && !burst_last) begin
      mem_we = 1'b1;          // beats 1 to 3
    end
  end

  assign rd_load = (state == READ_DELAY && lat_last) ||
                   (state == READ_BURST && !burst_last);

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= ram_req.wr_data;
    end
    if (rd_load) begin
      rd_data_q <= mem[addr_cnt];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= INITIATE;
      init_cnt   <= '0;
      lat_cnt    <= '0;
      burst_cnt  <= '0;
      addr_cnt   <= '0;
      rd_valid_q <= 1'b0;
      calib_q    <= 1'b0;
      busy_q     <= 1'b1;  // busy until calibrated
    end else begin
      case (state)
        INITIATE: begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt == INIT_CNT_W'(INIT_CYCLES)) begin
            calib_q <= 1'b1;
            busy_q  <= 1'b0;
            state   <= IDLE;
          end
        end
        IDLE: ;  // commands handled below
        READ_DELAY: begin
          lat_cnt <= lat_cnt + 1'b1;
          if (lat_last) begin
            rd_valid_q <= 1'b1;            // first beat out
            addr_cnt   <= addr_cnt + 1'b1;
            state      <= READ_BURST;
          end
        end
        READ_BURST, WRITE_BURST: begin
          burst_cnt <= burst_cnt + 1'b1;
          addr_cnt  <= addr_cnt + 1'b1;
          if (burst_last) begin
            rd_valid_q <= 1'b0;
            busy_q     <= 1'b0;
            state      <= IDLE;
          end
        end
        default: state <= INITIATE;
      endcase

      // overrides the end of a burst when a new command follows directly
      if (accept) begin
        busy_q    <= 1'b1;
        burst_cnt <= '0;
        lat_cnt   <= '0;
        if (ram_req.cmd == CMD_WRITE) begin
          addr_cnt <= ram_req.addr + 1'b1;  // beat 0 already stored
          state    <= WRITE_BURST;
        end else begin
          addr_cnt <= ram_req.addr;
          state    <= READ_DELAY;
        end
      end
    end
  end

  assign ram_rsp.rd_data       = rd_data_q;
  assign ram_rsp.rd_data_valid = rd_valid_q;
  assign ram_rsp.init_calib    = calib_q;
  assign ram_rsp.busy          = busy_q;

endmodule

/* source/line_store.sv */
/*
 * storage of the single cached line with tag, valid and dirty
 * word port with byte selects, beat port for RAM bursts
 */

module line_store
  import burst_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  word_we,
  input  logic [WB_SEL_W-1:0]   word_sel,
  input  logic [WORD_IDX_W-1:0] word_adr,
  input  logic [WB_DATA_W-1:0]  word_wdata,
  output logic [WB_DATA_W-1:0]  word_rdata,
  input  logic                  beat_we,
  input  logic [BEAT_IDX_W-1:0] beat_idx,
  input  logic [RAM_DATA_W-1:0] beat_wdata,
  output logic [RAM_DATA_W-1:0] beat_rdata,
  input  logic                  set_tag,
  input  logic [TAG_W-1:0]      new_tag,
  input  logic                  clr_dirty,
  output logic [TAG_W-1:0]      tag,
  output logic                  valid,
  output logic                  dirty
);

  logic [LINE_W-1:0] line_q;  // word 0 sits in the low half of beat 0

  always_ff @(posedge clk) begin
    if (beat_we) begin
      line_q[beat_idx*RAM_DATA_W +: RAM_DATA_W] <= beat_wdata;
    end
    if (word_we) begin
      for (int b = 0; b < WB_SEL_W; b++) begin
        if (word_sel[b]) begin
          line_q[word_adr*WB_DATA_W + b*8 +: 8] <= word_wdata[b*8 +: 8];
        end
      end
    end
  end

  assign word_rdata = line_q[word_adr*WB_DATA_W +: WB_DATA_W];
  assign beat_rdata = line_q[beat_idx*RAM_DATA_W +: RAM_DATA_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag   <= '0;
      valid <= 1'b0;
      dirty <= 1'b0;
    end else begin
      if (set_tag) begin
        tag   <= new_tag;
        valid <= 1'b1;
      end
      if (word_we) begin
        dirty <= 1'b1;   // beat writes leave it alone
      end else if (clr_dirty) begin
        dirty <= 1'b0;   // line is back in RAM
      end
    end
  end

endmodule

/* source/burst_sequencer.sv */
/*
 * burst sequencer between the cache controller and the burst RAM
 * one fill or evict request becomes one four-beat RAM burst
 */

module burst_sequencer
  import burst_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  seq_req_t              seq_req,
  output logic                  seq_done,
  output ram_req_t              ram_req,
  input  ram_rsp_t              ram_rsp,
  output logic                  beat_we,
  output logic [BEAT_IDX_W-1:0] beat_idx,
  output logic [RAM_DATA_W-1:0] beat_wdata,
  input  logic [RAM_DATA_W-1:0] beat_rdata
);

  seq_state_e            state;
  seq_op_e               op_q;
  logic [TAG_W-1:0]      tag_q;
  logic [BEAT_IDX_W-1:0] beat_cnt;
  logic                  issue;
  logic                  beat_last;

  // only once calibrated and with the RAM idle
  assign issue     = (state == SEQ_ISSUE) && ram_rsp.init_calib && !ram_rsp.busy;
  assign beat_last = (beat_cnt == BEAT_IDX_W'(BURST_LEN - 1));

  assign ram_req.cmd_en  = issue;
  assign ram_req.cmd     = (op_q == SEQ_EVICT) ? CMD_WRITE : CMD_READ;
  assign ram_req.addr    = {tag_q, {BEAT_IDX_W{1'b0}}};  // tag * BURST_LEN
  assign ram_req.wr_data = beat_rdata;                   // beat 0 during the issue cycle

  assign beat_idx   = beat_cnt;
  assign beat_we    = (state == SEQ_RD_BEATS) && ram_rsp.rd_data_valid;
  assign beat_wdata = ram_rsp.rd_data;

  // fill ends a cycle after the last beat, evict when busy drops
  assign seq_done = (state == SEQ_DONE) || (state == SEQ_WR_WAIT && !ram_rsp.busy);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= SEQ_IDLE;
      op_q     <= SEQ_FILL;
      tag_q    <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (seq_req.start) begin
            op_q     <= seq_req.op;
            tag_q    <= seq_req.tag;
            beat_cnt <= '0;
            state    <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          if (issue) begin
            if (op_q == SEQ_EVICT) begin
              beat_cnt <= beat_cnt + 1'b1;
              state    <= SEQ_WR_BEATS;
            end else begin
              state <= SEQ_RD_BEATS;
            end
          end
        end
        SEQ_WR_BEATS: begin
          beat_cnt <= beat_cnt + 1'b1;    // one beat per cycle, no stalls
          if (beat_last) begin
            state <= SEQ_WR_WAIT;
          end
        end
        SEQ_WR_WAIT: begin
          if (!ram_rsp.busy) begin
            state <= SEQ_IDLE;
          end
        end
        SEQ_RD_BEATS: begin
          if (ram_rsp.rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_last) begin
              state <= SEQ_DONE;
            end
          end
        end
        SEQ_DONE: state <= SEQ_IDLE;
        default:  state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

/* source/line_cache_ctrl.sv */
/*
 * wishbone classic slave of the one-line write-back cache
 * hit and miss detection, evict before fill, byte-select writes
 */

module line_cache_ctrl
  import burst_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  wb_req_t               wb_i,
  output wb_rsp_t               wb_o,
  output seq_req_t              seq_req,
  input  logic                  seq_done,
  output logic                  word_we,
  output logic [WB_SEL_W-1:0]   word_sel,
  output logic [WORD_IDX_W-1:0] word_adr,
  output logic [WB_DATA_W-1:0]  word_wdata,
  input  logic [WB_DATA_W-1:0]  word_rdata,
  output logic                  set_tag,
  output logic [TAG_W-1:0]      new_tag,
  output logic                  clr_dirty,
  input  logic [TAG_W-1:0]      tag,
  input  logic                  valid,
  input  logic                  dirty
);

  ctrl_state_e          state;
  logic                 ack_q;
  logic [WB_DATA_W-1:0] dat_q;
  logic                 start_q;
  seq_op_e              op_q;
  logic [TAG_W-1:0]     seq_tag_q;

  logic                 req;
  logic                 hit;
  logic                 access;

  assign req     = wb_i.cyc && wb_i.stb && !ack_q;       // stb may linger in the ack cycle
  assign new_tag = wb_i.adr[WB_ADR_W-1 -: TAG_W];
  assign hit     = valid && (tag == new_tag);

  // served on a hit, or in the same cycle the fill completes
  assign access = (state == CTRL_IDLE && req && hit) || (state == CTRL_FILL && seq_done);

  assign word_we    = access && wb_i.we;
  assign word_sel   = wb_i.sel;
  assign word_adr   = wb_i.adr[WORD_IDX_W-1:0];
  assign word_wdata = wb_i.dat_w;
  assign set_tag    = (state == CTRL_FILL) && seq_done;
  assign clr_dirty  = (state == CTRL_EVICT) && seq_done;

  assign wb_o.dat_r = dat_q;
  assign wb_o.ack   = ack_q;

  assign seq_req.start = start_q;
  assign seq_req.op    = op_q;
  assign seq_req.tag   = seq_tag_q;

  always_ff @(posedge clk) begin
    if (access) begin
      dat_q <= word_rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= CTRL_IDLE;
      ack_q     <= 1'b0;
      start_q   <= 1'b0;
      op_q      <= SEQ_FILL;
      seq_tag_q <= '0;
    end else begin
      ack_q   <= access;  // single-cycle pulse
      start_q <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          if (req && !hit) begin
            start_q <= 1'b1;
            if (valid && dirty) begin
              op_q      <= SEQ_EVICT;   // old line goes back first
              seq_tag_q <= tag;
              state     <= CTRL_EVICT;
            end else begin
              op_q      <= SEQ_FILL;
              seq_tag_q <= new_tag;
              state     <= CTRL_FILL;
            end
          end
        end
        CTRL_EVICT: begin
          if (seq_done) begin
            start_q   <= 1'b1;
            op_q      <= SEQ_FILL;
            seq_tag_q <= new_tag;
            state     <= CTRL_FILL;
          end
        end
        CTRL_FILL: begin
          if (seq_done) begin
            state <= CTRL_IDLE;
          end
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

endmodule

/* source/burst_mem_top.sv */
/*
 * top level of the burst memory subsystem
 * cache controller, line store, burst sequencer and burst RAM model
 */

module burst_mem_top
  import burst_mem_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_i,
  output wb_rsp_t wb_o
);

  seq_req_t              seq_req;
  logic                  seq_done;
  ram_req_t              ram_req;
  ram_rsp_t              ram_rsp;

  // word and meta port, controller side
  logic                  word_we;
  logic [WB_SEL_W-1:0]   word_sel;
  logic [WORD_IDX_W-1:0] word_adr;
  logic [WB_DATA_W-1:0]  word_wdata;
  logic [WB_DATA_W-1:0]  word_rdata;
  logic                  set_tag;
  logic [TAG_W-1:0]      new_tag;
  logic                  clr_dirty;
  logic [TAG_W-1:0]      tag;
  logic                  valid;
  logic                  dirty;

  // beat port, sequencer side
  logic                  beat_we;
  logic [BEAT_IDX_W-1:0] beat_idx;
  logic [RAM_DATA_W-1:0] beat_wdata;
  logic [RAM_DATA_W-1:0] beat_rdata;

  line_cache_ctrl ctrl_i (
    .clk, .rst_n, .wb_i, .wb_o, .seq_req, .seq_done,
    .word_we, .word_sel, .word_adr, .word_wdata, .word_rdata,
    .set_tag, .new_tag, .clr_dirty, .tag, .valid, .dirty
  );

  line_store store_i (
    .clk, .rst_n, .word_we, .word_sel, .word_adr, .word_wdata, .word_rdata,
    .beat_we, .beat_idx, .beat_wdata, .beat_rdata,
    .set_tag, .new_tag, .clr_dirty, .tag, .valid, .dirty
  );

  burst_sequencer seq_i (
    .clk, .rst_n, .seq_req, .seq_done, .ram_req, .ram_rsp,
    .beat_we, .beat_idx, .beat_wdata, .beat_rdata
  );

  burst_ram ram_i (
    .clk, .rst_n, .ram_req, .ram_rsp
  );

endmodule

/* dv/burst_mem_assertions.sv */
/*
 * concurrent protocol assertions for the burst memory subsystem
 * wishbone ack rules, RAM command rule, read burst length
 */

module burst_mem_assertions
  import burst_mem_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input wb_req_t  wb_i,
  input wb_rsp_t  wb_o,
  input ram_req_t ram_req,
  input ram_rsp_t ram_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  int         fail_cnt = 0;  // read by the testbench
  logic [2:0] valid_run;     // consecutive rd_data_valid cycles so far

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_run <= '0;
    end else if (ram_rsp.rd_data_valid) begin
      if (valid_run != 3'd7) begin
        valid_run <= valid_run + 1'b1;  // saturates
      end
    end else begin
      valid_run <= '0;
    end
  end

  ack_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.ack |=> !wb_o.ack)
    else begin
      $error("wishbone ack high in two consecutive cycles");
      fail_cnt++;
    end

  ack_inside_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.ack |-> (wb_i.cyc && wb_i.stb))
    else begin
      $error("wishbone ack high without cyc and stb");
      fail_cnt++;
    end

  cmd_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ram_req.cmd_en |-> (ram_rsp.init_calib && !ram_rsp.busy))
    else begin
      $error("RAM command issued before calibration or while busy");
      fail_cnt++;
    end

  // the current cycle counts as one more beat
  read_burst_length: assert property (@(posedge clk) disable iff (!rst_n)
    ram_rsp.rd_data_valid |-> (valid_run < BURST_LEN))
    else begin
      $error("rd_data_valid high for more than one burst");
      fail_cnt++;
    end

endmodule

bind burst_mem_top burst_mem_assertions assert_i (
  .clk, .rst_n, .wb_i, .wb_o, .ram_req, .ram_rsp
);

/* dv/tb_burst_mem_top.sv */
/*
 * testbench of the burst memory subsystem
 * directed and random wishbone accesses against a reference memory
 */

module tb_burst_mem_top
  import burst_mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ACK_TIMEOUT = 200;  // cycles per access
  localparam int RANDOM_OPS  = 400;

  logic    clk = 1'b0;
  logic    rst_n;
  wb_req_t wb_i;
  wb_rsp_t wb_o;

  logic [WB_DATA_W-1:0] ref_mem [2**WB_ADR_W];  // reference copy of the whole memory
  logic [TAG_W-1:0]     model_tag;              // line the cache should hold
  logic                 model_valid;

  always #5 clk = ~clk;

  burst_mem_top dut_i (.clk, .rst_n, .wb_i, .wb_o);

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_read(input string test, input logic [WB_DATA_W-1:0] exp,
                            input wb_rsp_t rsp);
    if (rsp.dat_r !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected %08h actual %08h", test, exp, rsp.dat_r));
    end
  endtask

  task automatic check_hit_latency(input string test, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("MISMATCH %s: expected hit ack after %0d cycles actual %0d",
                          test, exp, act));
    end
  endtask

  task automatic model_write(input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] dat,
                             input logic [WB_SEL_W-1:0] sel);
    for (int b = 0; b < WB_SEL_W; b++) begin
      if (sel[b]) begin
        ref_mem[adr][b*8 +: 8] = dat[b*8 +: 8];
      end
    end
  endtask

  // one classic cycle, entered and left on a falling edge
  task automatic run_access(input string test, input logic we,
                            input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DATA_W-1:0] dat,
                            input logic [WB_SEL_W-1:0] sel,
                            output wb_rsp_t rsp);
    logic hit;
    int   waited;
    hit = model_valid && (model_tag == adr[WB_ADR_W-1 -: TAG_W]);
    wb_i.cyc   = 1'b1;
    wb_i.stb   = 1'b1;
    wb_i.we    = we;
    wb_i.adr   = adr;
    wb_i.dat_w = dat;
    wb_i.sel   = sel;
    @(negedge clk);
    waited = 1;
    while (!wb_o.ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_o.ack) begin
      abort_run($sformatf("%s: no ack within %0d cycles at address %02h",
                          test, ACK_TIMEOUT, adr));
    end
    rsp = wb_o;
    @(negedge clk);                   // ack gets sampled on the next rising edge
    wb_i.cyc = 1'b0;
    wb_i.stb = 1'b0;
    wb_i.we  = 1'b0;
    @(negedge clk);                   // stb low for one cycle
    if (hit) begin
      check_hit_latency(test, 1, waited);
    end
    model_tag   = adr[WB_ADR_W-1 -: TAG_W];
    model_valid = 1'b1;
    if (we) begin
      model_write(adr, dat, sel);
    end
    if (dut_i.assert_i.fail_cnt != 0) begin
      abort_run($sformatf("%s: a protocol assertion failed", test));
    end
  endtask

  task automatic write_word(input string test, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DATA_W-1:0] dat,
                            input logic [WB_SEL_W-1:0] sel);
    wb_rsp_t rsp;
    run_access(test, 1'b1, adr, dat, sel, rsp);
  endtask

  task automatic read_word(input string test, input logic [WB_ADR_W-1:0] adr);
    wb_rsp_t rsp;
    run_access(test, 1'b0, adr, '0, '1, rsp);
    check_read(test, ref_mem[adr], rsp);
  endtask

  initial begin
    logic [WB_ADR_W-1:0]  adr;
    logic [WB_DATA_W-1:0] dat;
    logic [WB_SEL_W-1:0]  sel;
    void'($urandom(32'hfab1));
    foreach (ref_mem[i]) begin
      ref_mem[i] = '0;
    end
    model_tag   = '0;
    model_valid = 1'b0;
    wb_i        = '0;
    rst_n       = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    read_word("read_zero", 7'h00);   // waits through calibration
    read_word("read_zero", 7'h05);
    read_word("read_zero", 7'h4b);
    read_word("read_zero", 7'h7f);

    write_word("full_write", 7'h12, 32'hdeadbeef, 4'hf);
    read_word("full_write", 7'h12);

    write_word("partial_sel", 7'h13, 32'h11223344, 4'hf);
    write_word("partial_sel", 7'h13, 32'haabbccdd, 4'b0101);
    read_word("partial_sel", 7'h13);
    write_word("partial_sel", 7'h14, 32'h99887766, 4'b1000);
    read_word("partial_sel", 7'h14);

    // second write evicts the dirty first line, the reads refill both
    write_word("two_lines", 7'h20, 32'hcafe0020, 4'hf);
    write_word("two_lines", 7'h48, 32'hbeef0048, 4'hf);
    read_word("two_lines", 7'h20);
    read_word("two_lines", 7'h48);

    read_word("hit_timing", 7'h4f);  // same line as the last access
    write_word("hit_timing", 7'h49, 32'h0badf00d, 4'b0011);
    read_word("hit_timing", 7'h49);

    for (int i = 0; i < RANDOM_OPS; i++) begin
      adr = WB_ADR_W'($urandom_range(2**WB_ADR_W - 1));
      if ($urandom_range(1) == 0) begin
        adr[WB_ADR_W-1 -: TAG_W] = model_tag;  // stay on the cached line half the time
      end
      dat = $urandom;
      sel = WB_SEL_W'($urandom);
      if ($urandom_range(1) == 1) begin
        write_word("random", adr, dat, sel);
      end else begin
        read_word("random", adr);
      end
    end

    if (dut_i.assert_i.fail_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

/* burst_mem_top.f */
source/burst_mem_pkg.sv
source/burst_ram.sv
source/line_store.sv
source/burst_sequencer.sv
source/line_cache_ctrl.sv
source/burst_mem_top.sv
dv/burst_mem_assertions.sv
dv/tb_burst_mem_top.sv
